/* Makefile */
TOP = mac_stats_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

/* dv/mac_stats_sva.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mac_stats_settings.svh"

module mac_stats_sva
    import mac_stats_pkg::*;
(
     input  wire                            clk
    ,input  wire                            arst_n
    ,input  wire                            tx_val
    ,input  wire                            tx_rdy
    ,input  wire mac_beat_t                 tx_beat
    ,input  wire    [`MTU_SIZE_W-1:0]       tx_frame_size
    ,input  wire                            resp_val
);
    // a stalled beat waits unchanged at the head of the queue
    tx_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
        tx_val && !tx_rdy |=> tx_val && $stable(tx_beat) && $stable(tx_frame_size))
        else $error("tx beat or frame size changed under stall");

    resp_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        resp_val |=> !resp_val)
        else $error("resp_val high for more than one cycle");

    tx_idle_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !tx_val)  // engine is still clearing
        else $error("tx_val high right after reset");

    // the counters are read for the finished frame before the next beat is offered
    tx_idle_after_frame: assert property (@(posedge clk) disable iff (!arst_n)
        tx_val && tx_rdy && tx_beat.endframe |=> !tx_val)
        else $error("tx_val high in the cycle after a frame ended");

endmodule

bind mac_stats_top mac_stats_sva sva (
     .clk           (clk            )
    ,.arst_n        (arst_n         )
    ,.tx_val        (tx_val         )
    ,.tx_rdy        (tx_rdy         )
    ,.tx_beat       (tx_beat        )
    ,.tx_frame_size (tx_frame_size  )
    ,.resp_val      (resp_val       )
);

`default_nettype wire

/* dv/mac_stats_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mac_stats_settings.svh"

module mac_stats_tb
    import mac_stats_pkg::*;
();
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int NUM_BUCKETS = 2 ** `STATS_ADDR_W;
    localparam int NUM_RANDOM_FRAMES = 30;
    localparam int NUM_FILL_FRAMES = 12;

    logic                           clk;
    logic                           arst_n;
    logic                           rx_val;
    mac_beat_t                      rx_beat;
    logic                           rx_rdy;
    logic                           tx_val;
    logic                           tx_rdy;
    mac_beat_t                      tx_beat;
    logic   [`MTU_SIZE_W-1:0]       tx_frame_size;
    logic                           query_val;
    logic   [`STATS_ADDR_W-1:0]     query_bucket;
    logic                           resp_val;
    logic   [`STATS_DATA_W-1:0]     resp_frames;
    logic   [`STATS_DATA_W-1:0]     resp_bytes;

    mac_beat_t                      ref_beats [$];
    int                             ref_sizes [$];
    logic   [31:0]                  model_frames [NUM_BUCKETS];
    logic   [31:0]                  model_bytes [NUM_BUCKETS];
    logic   [31:0]                  data_seed;
    logic   [31:0]                  rdy_seed;
    int                             err_cnt = 0;
    int                             test_cnt = 0;
    int                             test_err_base = 0;
    int                             cycle_cnt = 0;

    mac_stats_top UUT (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.rx_val        (rx_val         )
        ,.rx_beat       (rx_beat        )
        ,.rx_rdy        (rx_rdy         )
        ,.tx_val        (tx_val         )
        ,.tx_rdy        (tx_rdy         )
        ,.tx_beat       (tx_beat        )
        ,.tx_frame_size (tx_frame_size  )
        ,.query_val     (query_val      )
        ,.query_bucket  (query_bucket   )
        ,.resp_val      (resp_val       )
        ,.resp_frames   (resp_frames    )
        ,.resp_bytes    (resp_bytes     )
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        $display("%s done with %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // beats go into the reference queue as the queue accepts them
    task automatic send_frame(input int nbeats, input int pad);
        mac_beat_t beat;
        int size;
        int bucket;
        logic accepted;
        size = nbeats * 4 - pad;
        for (int i = 0; i < nbeats; i++) begin
            data_seed = lcg_step(data_seed);
            beat.data = data_seed;
            beat.startframe = (i == 0);
            beat.endframe = (i == nbeats - 1);
            beat.padbytes = (i == nbeats - 1) ? pad[1:0] : 2'd0;
            rx_beat = beat;
            rx_val = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = rx_rdy;
                if (accepted) begin
                    ref_beats.push_back(beat);
                    ref_sizes.push_back(size);
                end
                @(posedge clk);
                #1;
            end
        end
        rx_val = 1'b0;
        bucket = size >> `STATS_BUCKET_SHIFT;
        if (bucket > NUM_BUCKETS - 1) begin
            bucket = NUM_BUCKETS - 1;   // the last bucket takes every larger frame
        end
        model_frames[bucket] += 1;
        model_bytes[bucket] += size;
    endtask

    task automatic expect_frame(input int rdy_pct);
        mac_beat_t exp_beat;
        int exp_size;
        logic done;
        done = 1'b0;
        while (!done) begin
            rdy_seed = lcg_step(rdy_seed);
            tx_rdy = (int'(rdy_seed[31:24]) % 100) < rdy_pct;
            @(negedge clk);
            if (tx_val && tx_rdy) begin
                if (ref_beats.size() == 0) begin
                    $display("unexpected transmit beat at %0t ns with nothing sent", $time);
                    err_cnt++;
                    done = 1'b1;
                end else begin
                    exp_beat = ref_beats.pop_front();
                    exp_size = ref_sizes.pop_front();
                    check_value("tx_beat", 64'(tx_beat), 64'(exp_beat));
                    check_value("tx_frame_size", 64'(tx_frame_size), 64'(exp_size));
                    done = exp_beat.endframe;
                end
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_bucket(input int bucket, output logic [31:0] frames,
                               output logic [31:0] bytes_out);
        logic got;
        query_val = 1'b1;
        query_bucket = bucket[`STATS_ADDR_W-1:0];
        @(posedge clk);
        #1;
        query_val = 1'b0;
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            if (resp_val) begin
                got = 1'b1;
                frames = resp_frames;
                bytes_out = resp_bytes;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic clear_after_reset();
        logic [31:0] frames;
        logic [31:0] bytes_out;
        for (int b = 0; b < NUM_BUCKETS; b++) begin
            read_bucket(b, frames, bytes_out);
            check_value($sformatf("frames of bucket %0d", b), 64'(frames), 64'd0);
            check_value($sformatf("bytes of bucket %0d", b), 64'(bytes_out), 64'd0);
        end
        report_test("clear after reset");
    endtask

    task automatic single_frame_passes();
        fork
            send_frame(10, 3);   // 37 bytes
            expect_frame(100);
        join
        tx_rdy = 1'b0;
        check_value("beats left over", 64'(ref_beats.size()), 64'd0);
        report_test("single frame");
    endtask

    task automatic random_frames_in_order();
        int lens [NUM_RANDOM_FRAMES];
        int pads [NUM_RANDOM_FRAMES];
        for (int i = 0; i < NUM_RANDOM_FRAMES; i++) begin
            data_seed = lcg_step(data_seed);
            lens[i] = 1 + int'(data_seed[31:16] % 16'd40);
            data_seed = lcg_step(data_seed);
            pads[i] = int'(data_seed[31:30]);
        end
        fork
            for (int i = 0; i < NUM_RANDOM_FRAMES; i++) send_frame(lens[i], pads[i]);
            for (int j = 0; j < NUM_RANDOM_FRAMES; j++) expect_frame(50);
        join
        tx_rdy = 1'b0;
        check_value("beats left over", 64'(ref_beats.size()), 64'd0);
        report_test("random frames");
    endtask

    task automatic counter_totals_match();
        logic [31:0] frames;
        logic [31:0] bytes_out;
        for (int b = 0; b < NUM_BUCKETS; b++) begin
            read_bucket(b, frames, bytes_out);
            check_value($sformatf("frames of bucket %0d", b), 64'(frames),
                        64'(model_frames[b]));
            check_value($sformatf("bytes of bucket %0d", b), 64'(bytes_out),
                        64'(model_bytes[b]));
        end
        report_test("counter totals");
    endtask

    task automatic queue_backpressure();
        logic saw_full;
        int held;
        saw_full = 1'b0;
        held = 0;
        fork
            for (int i = 0; i < NUM_FILL_FRAMES; i++) send_frame(8, i % 4);
            begin
                tx_rdy = 1'b0;
                while (!saw_full) begin
                    @(negedge clk);
                    if (!rx_rdy) begin
                        saw_full = 1'b1;
                        held = ref_beats.size();
                    end
                    @(posedge clk);
                    #1;
                end
                for (int j = 0; j < NUM_FILL_FRAMES; j++) expect_frame(100);
            end
        join
        tx_rdy = 1'b0;
        // the data FIFO holds 64 beats at most
        check_value("beats held when rx_rdy dropped", 64'(held <= 64), 64'd1);
        check_value("beats left over", 64'(ref_beats.size()), 64'd0);
        report_test("queue back-pressure");
    endtask

    initial begin
        arst_n = 1'b0;
        rx_val = 1'b0;
        rx_beat = '0;
        tx_rdy = 1'b0;
        query_val = 1'b0;
        query_bucket = '0;
        data_seed = 32'd36;
        rdy_seed = lcg_step(32'd36);
        for (int b = 0; b < NUM_BUCKETS; b++) begin
            model_frames[b] = '0;
            model_bytes[b] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        clear_after_reset();
        single_frame_passes();
        random_frames_in_order();
        counter_totals_match();
        queue_backpressure();

        $display("tests run: %0d, errors: %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/mac_stats_pkg.sv */
`default_nettype none
`include "mac_stats_settings.svh"

package mac_stats_pkg;

    typedef struct packed {
        logic   [`MAC_INTERFACE_W-1:0]  data;
        logic                           startframe;
        logic                           endframe;
        logic   [`MAC_PADBYTES_W-1:0]   padbytes;   // unused bytes of the last beat
    } mac_beat_t;

    typedef struct packed {
        logic                           en;
        logic                           wr_en;
        logic   [`STATS_ADDR_W-1:0]     addr;
        logic   [`STATS_DATA_W-1:0]     wdata;
        logic   [`STATS_DATA_W/8-1:0]   mask;       // one bit per byte lane
    } stats_mem_req_t;

    typedef enum logic [2:0] {
        CLEAR,
        FORWARD,
        LOOKUP,
        UPDATE,
        QUERY
    } stats_state_t;

endpackage

`default_nettype wire

/* hw/mac_stats_settings.svh */
`ifndef MAC_STATS_SETTINGS_SVH
`define MAC_STATS_SETTINGS_SVH

// MAC beat is four bytes wide
`define MAC_INTERFACE_W     32
`define MAC_PADBYTES_W      2
`define MTU_SIZE_W          11

// queue depths, log2
`define PKT_QUEUE_LOG_ELS   6
`define SIZE_QUEUE_LOG_ELS  3

// 16 buckets of 32-bit counters
`define STATS_ADDR_W        4
`define STATS_DATA_W        32

// frame size right-shifted by this gives the bucket, saturated at the last one
`define STATS_BUCKET_SHIFT  6

`endif

/* hw/mac_stats_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mac_stats_settings.svh"

module mac_stats_top
    import mac_stats_pkg::*;
(
     input  wire                            clk
    ,input  wire                            arst_n

    ,input  wire                            rx_val
    ,input  wire mac_beat_t                 rx_beat
    ,output logic                           rx_rdy

    ,output logic                           tx_val
    ,input  wire                            tx_rdy
    ,output mac_beat_t                      tx_beat
    ,output logic   [`MTU_SIZE_W-1:0]       tx_frame_size

    ,input  wire                            query_val
    ,input  wire    [`STATS_ADDR_W-1:0]     query_bucket
    ,output logic                           resp_val
    ,output logic   [`STATS_DATA_W-1:0]     resp_frames
    ,output logic   [`STATS_DATA_W-1:0]     resp_bytes
);
    logic                               q_wr_req;
    logic                               q_full;
    logic                               q_empty;
    logic                               q_val;
    logic                               q_rd;
    mac_beat_t                          q_beat;

    logic                               size_rd_req;
    logic   [`MTU_SIZE_W-1:0]           size_rd_data;
    logic   [`MTU_SIZE_W-1:0]           frame_size;

    stats_mem_req_t                     req_frames;
    stats_mem_req_t                     req_bytes;
    logic   [`STATS_DATA_W-1:0]         frames_dout;
    logic   [`STATS_DATA_W-1:0]         bytes_dout;
    logic                               frames_dout_val;

    assign rx_rdy = ~q_full;
    assign q_wr_req = rx_val & rx_rdy;
    assign q_val = ~q_empty;

    packet_queue_controller rx_pkt_queue (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.wr_req        (q_wr_req       )
        ,.wr_data       (rx_beat        )
        ,.full          (q_full         )
        ,.rd_req        (q_rd           )
        ,.empty         (q_empty        )
        ,.rd_data       (q_beat         )
        ,.size_rd_req   (size_rd_req    )
        ,.size_rd_data  (size_rd_data   )
    );

    packet_size_queue_reader size_reader (
         .clk           (clk                )
        ,.arst_n        (arst_n             )
        ,.q_val         (q_val              )
        ,.q_startframe  (q_beat.startframe  )
        ,.q_rd          (q_rd               )
        ,.size_rd_req   (size_rd_req        )
        ,.size_rd_data  (size_rd_data       )
        ,.frame_size    (frame_size         )
    );

    stats_engine engine (
         .clk               (clk            )
        ,.arst_n            (arst_n         )
        ,.q_val             (q_val          )
        ,.q_beat            (q_beat         )
        ,.frame_size        (frame_size     )
        ,.q_rd              (q_rd           )
        ,.tx_val            (tx_val         )
        ,.tx_rdy            (tx_rdy         )
        ,.tx_beat           (tx_beat        )
        ,.tx_frame_size     (tx_frame_size  )
        ,.query_val         (query_val      )
        ,.query_bucket      (query_bucket   )
        ,.resp_val          (resp_val       )
        ,.resp_frames       (resp_frames    )
        ,.resp_bytes        (resp_bytes     )
        ,.req_frames        (req_frames     )
        ,.req_bytes         (req_bytes      )
        ,.frames_dout       (frames_dout    )
        ,.bytes_dout        (bytes_dout     )
        ,.frames_dout_val   (frames_dout_val)
    );

    stats_ram frames_ram (
         .clk       (clk            )
        ,.arst_n    (arst_n         )
        ,.req       (req_frames     )
        ,.dout      (frames_dout    )
        ,.dout_val  (frames_dout_val)
    );

    // both RAMs move in lockstep so one valid flag serves the engine
    stats_ram bytes_ram (
         .clk       (clk        )
        ,.arst_n    (arst_n     )
        ,.req       (req_bytes  )
        ,.dout      (bytes_dout )
        ,.dout_val  (           )
    );

endmodule

`default_nettype wire

/* hw/packet_queue_controller.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mac_stats_settings.svh"

module packet_queue_controller
    import mac_stats_pkg::*;
(
     input  wire                            clk
    ,input  wire                            arst_n

    ,input  wire                            wr_req
    ,input  wire mac_beat_t                 wr_data
    ,output logic                           full

    ,input  wire                            rd_req
    ,output logic                           empty
    ,output mac_beat_t                      rd_data

    ,input  wire                            size_rd_req
    ,output logic   [`MTU_SIZE_W-1:0]       size_rd_data
);
    localparam int DATA_ELS = 2 ** `PKT_QUEUE_LOG_ELS;
    localparam int SIZE_ELS = 2 ** `SIZE_QUEUE_LOG_ELS;
    localparam logic [`MTU_SIZE_W-1:0] BEAT_BYTES = `MAC_INTERFACE_W / 8;

    mac_beat_t                          data_mem [DATA_ELS];
    logic   [`PKT_QUEUE_LOG_ELS:0]      wr_ptr;
    logic   [`PKT_QUEUE_LOG_ELS:0]      rd_ptr;

    logic   [`MTU_SIZE_W-1:0]           size_mem [SIZE_ELS];
    logic   [`SIZE_QUEUE_LOG_ELS:0]     size_wr_ptr;
    logic   [`SIZE_QUEUE_LOG_ELS:0]     size_rd_ptr;

    logic   [`MTU_SIZE_W-1:0]           byte_acc;
    logic   [`MTU_SIZE_W-1:0]           frame_bytes;
    logic   [`MTU_SIZE_W-1:0]           pad_ext;
    logic   [`PKT_QUEUE_LOG_ELS:0]      frame_cnt;

    logic                               data_full;
    logic                               size_full;
    logic                               size_empty;
    logic                               push;
    logic                               pop;
    logic                               size_push;
    logic                               size_pop;

    // pointers carry one extra wrap bit to tell full from empty
    assign data_full = (wr_ptr[`PKT_QUEUE_LOG_ELS] != rd_ptr[`PKT_QUEUE_LOG_ELS])
                    && (wr_ptr[`PKT_QUEUE_LOG_ELS-1:0] == rd_ptr[`PKT_QUEUE_LOG_ELS-1:0]);
    assign size_full = (size_wr_ptr[`SIZE_QUEUE_LOG_ELS] != size_rd_ptr[`SIZE_QUEUE_LOG_ELS])
                    && (size_wr_ptr[`SIZE_QUEUE_LOG_ELS-1:0]
                        == size_rd_ptr[`SIZE_QUEUE_LOG_ELS-1:0]);
    assign size_empty = size_wr_ptr == size_rd_ptr;

    // a full size FIFO also blocks writes since the next endframe has nowhere to go
    assign full = data_full | size_full;

    // only whole frames are visible to the reader
    assign empty = frame_cnt == '0;

    assign push = wr_req & ~full;
    assign pop = rd_req & ~empty;
    assign size_push = push & wr_data.endframe;
    assign size_pop = size_rd_req & ~size_empty;

    assign pad_ext = {{(`MTU_SIZE_W-`MAC_PADBYTES_W){1'b0}}, wr_data.padbytes};

    // running byte count of the frame including the beat being written
    assign frame_bytes = (wr_data.startframe ? '0 : byte_acc) + BEAT_BYTES - pad_ext;

    assign rd_data = data_mem[rd_ptr[`PKT_QUEUE_LOG_ELS-1:0]];
    assign size_rd_data = size_mem[size_rd_ptr[`SIZE_QUEUE_LOG_ELS-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr[`PKT_QUEUE_LOG_ELS-1:0]] <= wr_data;
        end
        if (size_push) begin
            size_mem[size_wr_ptr[`SIZE_QUEUE_LOG_ELS-1:0]] <= frame_bytes;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            size_wr_ptr <= '0;
            size_rd_ptr <= '0;
            byte_acc <= '0;
            frame_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
                byte_acc <= wr_data.endframe ? '0 : frame_bytes;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (size_push) begin
                size_wr_ptr <= size_wr_ptr + 1'b1;
            end
            if (size_pop) begin
                size_rd_ptr <= size_rd_ptr + 1'b1;
            end

            case ({size_push, pop & rd_data.endframe})
                2'b10:   frame_cnt <= frame_cnt + 1'b1;   // frame fully stored
                2'b01:   frame_cnt <= frame_cnt - 1'b1;   // last beat of a frame left
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/packet_size_queue_reader.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mac_stats_settings.svh"

module packet_size_queue_reader (
     input  wire                            clk
    ,input  wire                            arst_n

    ,input  wire                            q_val
    ,input  wire                            q_startframe
    ,input  wire                            q_rd

    ,output logic                           size_rd_req
    ,input  wire    [`MTU_SIZE_W-1:0]       size_rd_data
    ,output logic   [`MTU_SIZE_W-1:0]       frame_size
);
    logic                               first_rd;
    logic   [`MTU_SIZE_W-1:0]           size_hold;

    assign first_rd = q_val & q_startframe & q_rd;
    assign size_rd_req = first_rd;  // the size entry leaves with the first beat

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            size_hold <= '0;
        end else if (first_rd) begin
            size_hold <= size_rd_data;
        end
    end

    // head of the size FIFO belongs to the frame whose first beat is offered
    assign frame_size = (q_val & q_startframe) ? size_rd_data : size_hold;

endmodule

`default_nettype wire

/* hw/stats_engine.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mac_stats_settings.svh"

module stats_engine
    import mac_stats_pkg::*;
(
     input  wire                            clk
    ,input  wire                            arst_n

    ,input  wire                            q_val
    ,input  wire mac_beat_t                 q_beat
    ,input  wire    [`MTU_SIZE_W-1:0]       frame_size
    ,output logic                           q_rd

    ,output logic                           tx_val
    ,input  wire                            tx_rdy
    ,output mac_beat_t                      tx_beat
    ,output logic   [`MTU_SIZE_W-1:0]       tx_frame_size

    ,input  wire                            query_val
    ,input  wire    [`STATS_ADDR_W-1:0]     query_bucket
    ,output logic                           resp_val
    ,output logic   [`STATS_DATA_W-1:0]     resp_frames
    ,output logic   [`STATS_DATA_W-1:0]     resp_bytes

    ,output stats_mem_req_t                 req_frames
    ,output stats_mem_req_t                 req_bytes
    ,input  wire    [`STATS_DATA_W-1:0]     frames_dout
    ,input  wire    [`STATS_DATA_W-1:0]     bytes_dout
    ,input  wire                            frames_dout_val
);
    localparam logic [`STATS_ADDR_W-1:0] LAST_BUCKET = '1;

    stats_state_t                       state;
    logic   [`STATS_ADDR_W-1:0]         clr_addr;
    logic   [`STATS_ADDR_W-1:0]         bucket;
    logic   [`STATS_ADDR_W-1:0]         size_bucket;
    logic   [`MTU_SIZE_W-1:0]           size_shifted;
    logic   [`MTU_SIZE_W-1:0]           size_reg;
    logic                               in_frame;
    logic                               stalled;
    logic                               query_pend;
    logic   [`STATS_ADDR_W-1:0]         query_addr;
    logic                               query_phase;
    logic                               go_query;

    assign size_shifted = frame_size >> `STATS_BUCKET_SHIFT;
    assign size_bucket = (size_shifted > {{(`MTU_SIZE_W-`STATS_ADDR_W){1'b0}}, LAST_BUCKET})
                       ? LAST_BUCKET : size_shifted[`STATS_ADDR_W-1:0];

    // queries slip in between frames, never under a beat already offered
    assign go_query = query_pend & ~in_frame & ~stalled;

    assign tx_val = (state == FORWARD) & ~go_query & q_val;
    assign q_rd = tx_val & tx_rdy;
    assign tx_frame_size = frame_size;

    always_comb begin
        tx_beat = q_beat;
        tx_beat.startframe = q_beat.startframe & tx_val;
        tx_beat.endframe = q_beat.endframe & tx_val;
    end

    // both RAMs see the same request, only the write data differs
    always_comb begin
        req_frames = '0;
        req_frames.mask = '1;
        case (state)
            CLEAR: begin
                req_frames.en = 1'b1;
                req_frames.wr_en = 1'b1;
                req_frames.addr = clr_addr;
            end
            LOOKUP: begin
                req_frames.en = 1'b1;
                req_frames.addr = bucket;
            end
            UPDATE: begin
                req_frames.en = frames_dout_val;
                req_frames.wr_en = 1'b1;
                req_frames.addr = bucket;
                req_frames.wdata = frames_dout + 1'b1;
            end
            QUERY: begin
                req_frames.en = ~query_phase;
                req_frames.addr = query_addr;
            end
            default: begin
                req_frames.en = 1'b0;
            end
        endcase
        req_bytes = req_frames;
        if (state == UPDATE) begin
            req_bytes.wdata = bytes_dout
                            + {{(`STATS_DATA_W-`MTU_SIZE_W){1'b0}}, size_reg};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= CLEAR;
            clr_addr <= '0;
            in_frame <= 1'b0;
            stalled <= 1'b0;
            query_pend <= 1'b0;
            query_phase <= 1'b0;
            resp_val <= 1'b0;
        end else begin
            resp_val <= 1'b0;
            stalled <= tx_val & ~tx_rdy;
            if (query_val && !query_pend) begin
                query_pend <= 1'b1;
            end
            if (q_rd) begin
                in_frame <= ~q_beat.endframe;
            end

            case (state)
                CLEAR: begin
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == LAST_BUCKET) begin
                        state <= FORWARD;
                    end
                end
                FORWARD: begin
                    if (q_rd && q_beat.endframe) begin
                        state <= LOOKUP;
                    end else if (go_query) begin
                        state <= QUERY;
                    end
                end
                LOOKUP:  state <= UPDATE;
                UPDATE:  state <= query_pend ? QUERY : FORWARD;
                QUERY: begin
                    query_phase <= ~query_phase;
                    if (query_phase) begin
                        state <= FORWARD;
                        query_pend <= 1'b0;
                        resp_val <= frames_dout_val;
                    end
                end
                default: state <= CLEAR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_rd && q_beat.endframe) begin
            bucket <= size_bucket;
            size_reg <= frame_size;
        end
        if (query_val && !query_pend) begin
            query_addr <= query_bucket;
        end
        if (state == QUERY && query_phase) begin
            resp_frames <= frames_dout;
            resp_bytes <= bytes_dout;
        end
    end

endmodule

`default_nettype wire

/* hw/stats_ram.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mac_stats_settings.svh"

module stats_ram
    import mac_stats_pkg::*;
(
     input  wire                            clk
    ,input  wire                            arst_n

    ,input  wire stats_mem_req_t            req
    ,output logic   [`STATS_DATA_W-1:0]     dout
    ,output logic                           dout_val
);
    localparam int ELS = 2 ** `STATS_ADDR_W;
    localparam int BYTES = `STATS_DATA_W / 8;

    logic   [`STATS_DATA_W-1:0]         mem [ELS];

    always_ff @(posedge clk) begin
        if (req.en) begin
            if (req.wr_en) begin
                for (int i = 0; i < BYTES; i++) begin
                    if (req.mask[i]) begin
                        mem[req.addr][8*i +: 8] <= req.wdata[8*i +: 8];
                    end
                end
            end else begin
                dout <= mem[req.addr];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout_val <= 1'b0;
        end else begin
            dout_val <= req.en & ~req.wr_en;   // writes return nothing
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/mac_stats_pkg.sv
hw/packet_queue_controller.sv
hw/packet_size_queue_reader.sv
hw/stats_ram.sv
hw/stats_engine.sv
hw/mac_stats_top.sv
dv/mac_stats_sva.sv
dv/mac_stats_tb.sv
